// ==== rtl/obi_pkg.sv ====
/*
 * Processor-side bus definitions for the memory subsystem.
 * Holds the OBI request and response structs and the bus widths
 * shared by the fetch and lsu bridges and by the testbench.
 */

package obi_pkg;

	// ------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------

	// Byte address, full 32-bit space
	localparam int OBI_ADDR_W = 32;

	// Data word width
	localparam int OBI_DATA_W = 32;

	// One byte enable per data byte
	localparam int OBI_BE_W = OBI_DATA_W / 8;

	// ------------------------------------------------------------
	// Request and response channels
	// ------------------------------------------------------------

	// Request channel, driven by the master (core fetch or lsu)
	typedef struct packed {
		logic                  req;
		logic                  we;
		logic [OBI_BE_W-1:0]   be;
		logic [OBI_ADDR_W-1:0] addr;
		logic [OBI_DATA_W-1:0] wdata;
	} obi_req_t;

	// Response channel, driven by the slave bridge
	// gnt is combinational with req
	// No rready on OBI, so rvalid is never stalled
	typedef struct packed {
		logic                  gnt;
		logic                  rvalid;
		logic [OBI_DATA_W-1:0] rdata;
	} obi_rsp_t;

endpackage

// ==== rtl/mem_pkg.sv ====
/*
 * Memory-side definitions for the instruction and data SSRAMs.
 * Holds the SRAM port struct, the preload word format, the memory
 * target select and the loader FSM states.
 */

package mem_pkg;

	// ------------------------------------------------------------
	// SRAM geometry
	// ------------------------------------------------------------

	// Default word address width, 1024 words
	localparam int SRAM_ADDR_W = 10;
	localparam int SRAM_DATA_W = 32;
	localparam int SRAM_MASK_W = SRAM_DATA_W / 8;

	// SSRAM control, all strobes active low
	typedef struct packed {
		logic                   csb;
		logic                   web;
		logic [SRAM_MASK_W-1:0] wmask;
		logic [SRAM_ADDR_W-1:0] addr;
		logic [SRAM_DATA_W-1:0] din;
	} sram_port_t;

	// ------------------------------------------------------------
	// Preload
	// ------------------------------------------------------------

	// Which memory a load word goes to
	typedef enum logic [0:0] {
		TARGET_INSTR = 1'b0,
		TARGET_DATA  = 1'b1
	} mem_target_e;

	// One image word, addr is a word index
	typedef struct packed {
		mem_target_e            target;
		logic [SRAM_ADDR_W-1:0] addr;
		logic [SRAM_DATA_W-1:0] data;
	} load_word_t;

	// Loader FSM
	typedef enum logic [0:0] {
		ST_LOAD = 1'b0,
		ST_RUN  = 1'b1
	} loader_state_e;

endpackage

// ==== rtl/ssram_port.sv ====
/*
 * OBI slave bridge to one synchronous single-port SRAM.
 * Grants in the same cycle as req while enabled, drives the active-low
 * SRAM strobes for the accepted request and raises rvalid one cycle
 * later. Read data comes straight from the SRAM output register.
 * One instance sits on the fetch port and one on the lsu port.
 */

module ssram_port #(
	parameter int ADDR_W = mem_pkg::SRAM_ADDR_W
) (
	input  logic                 tb_CLK,
	input  logic                 arst_n,
	input  logic                 enable,
	input  obi_pkg::obi_req_t    obi_req,
	output obi_pkg::obi_rsp_t    obi_rsp,
	output mem_pkg::sram_port_t  sram_req,
	input  logic [31:0]          sram_dout
);

	import obi_pkg::*;
	import mem_pkg::*;

	// Lowest byte-address bit that selects a word
	localparam int WORD_LSB = $clog2(OBI_DATA_W / 8);

	// ------------------------------------------------------------
	// Request side
	// ------------------------------------------------------------

	// Grant follows req while the loader has handed over the SRAM
	logic gnt;

	// Request and grant in the same cycle
	logic accept;

	// Accepted write, goes to the SRAM as web low
	logic accept_wr;

	// Word index out of the byte address
	logic [ADDR_W-1:0] word_addr;

	// Response due on the next cycle
	logic rsp_pending_q;

	assign gnt       = obi_req.req & enable;
	assign accept    = obi_req.req & gnt;
	assign accept_wr = accept & obi_req.we;

	// Low two bits dropped, bus is word aligned
	assign word_addr = obi_req.addr[WORD_LSB +: ADDR_W];

	// SRAM strobes
	always_comb begin
		// Chip selected only for an accepted request
		sram_req.csb   = ~accept;
		// Write strobe low only for an accepted write
		sram_req.web   = ~accept_wr;
		// Byte enables map one to one onto the write mask
		sram_req.wmask = obi_req.be;
		// Zero extend when the array is shallower than the field
		sram_req.addr  = SRAM_ADDR_W'(word_addr);
		sram_req.din   = obi_req.wdata;
	end

	// ------------------------------------------------------------
	// Response side
	// ------------------------------------------------------------

	// SRAM read is registered, so data is ready one cycle after accept
	// Writes also get their rvalid here with rdata don't-care
	always_ff @(posedge tb_CLK or negedge arst_n) begin
		if (!arst_n) begin
			rsp_pending_q <= 1'b0;
		end else begin
			rsp_pending_q <= accept;
		end
	end

	// Response channel
	always_comb begin
		obi_rsp.gnt    = gnt;
		obi_rsp.rvalid = rsp_pending_q;
		// SRAM output register holds the read word for this cycle
		obi_rsp.rdata  = sram_dout;
	end

endmodule

// ==== rtl/sram_array.sv ====
/*
 * Behavioural 32-bit synchronous single-port SRAM.
 * Byte-masked write on the clock edge, one-cycle registered read.
 * Depth is 2^ADDR_W words, set by the top level.
 */

module sram_array #(
	parameter int ADDR_W = mem_pkg::SRAM_ADDR_W
) (
	input  logic                tb_CLK,
	input  mem_pkg::sram_port_t port,
	output logic [31:0]         dout
);

	import mem_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------

	logic [SRAM_DATA_W-1:0] mem [0:DEPTH-1];

	// Only the low ADDR_W bits of the port address are decoded
	logic [ADDR_W-1:0] row;

	assign row = port.addr[ADDR_W-1:0];

	// ------------------------------------------------------------
	// Access
	// ------------------------------------------------------------

	// csb low selects, web picks write or read
	// dout holds its last value when deselected or writing
	always_ff @(posedge tb_CLK) begin
		if (!port.csb) begin
			if (!port.web) begin
				// Merge only the enabled bytes
				for (int b = 0; b < SRAM_MASK_W; b++) begin
					if (port.wmask[b]) begin
						mem[row][8*b +: 8] <= port.din[8*b +: 8];
					end
				end
			end else begin
				// Read word appears after this edge
				dout <= mem[row];
			end
		end
	end

endmodule

// ==== rtl/mem_loader.sv ====
/*
 * Preload sequencer for the instruction and data memories.
 * After reset it owns both SRAM ports and writes each strobed load
 * word into the selected memory. A load_done strobe hands the ports
 * to the OBI bridges, raises their enable and releases core reset.
 */

module mem_loader #(
	parameter int ADDR_W = mem_pkg::SRAM_ADDR_W
) (
	input  logic                tb_CLK,
	input  logic                arst_n,
	input  logic                load_we,
	input  mem_pkg::load_word_t load_word,
	input  logic                load_done,
	input  mem_pkg::sram_port_t instr_req,
	input  mem_pkg::sram_port_t data_req,
	output mem_pkg::sram_port_t instr_port,
	output mem_pkg::sram_port_t data_port,
	output logic                enable,
	output logic                core_rst_n
);

	import mem_pkg::*;

	// Deselected port, no access
	localparam sram_port_t SRAM_IDLE = '{
		csb:   1'b1,
		web:   1'b1,
		wmask: '0,
		addr:  '0,
		din:   '0
	};

	loader_state_e state_q;
	loader_state_e state_d;

	// Full-word write built from the load port
	sram_port_t load_port;

	logic core_rst_n_q;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	// Single transition, ST_RUN is held until the next reset
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_LOAD: begin
				if (load_done) begin
					state_d = ST_RUN;
				end
			end
			ST_RUN:  state_d = ST_RUN;
			default: state_d = ST_LOAD;
		endcase
	end

	// Core reset rises on the same edge as the move to ST_RUN
	always_ff @(posedge tb_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state_q      <= ST_LOAD;
			core_rst_n_q <= 1'b0;
		end else begin
			state_q      <= state_d;
			core_rst_n_q <= (state_d == ST_RUN);
		end
	end

	assign enable     = (state_q == ST_RUN);
	assign core_rst_n = core_rst_n_q;

	// ------------------------------------------------------------
	// Port mux
	// ------------------------------------------------------------

	// Load words always write all four bytes
	always_comb begin
		load_port.csb   = 1'b0;
		load_port.web   = 1'b0;
		load_port.wmask = '1;
		// Wrap the index to the array depth
		load_port.addr  = SRAM_ADDR_W'(load_word.addr[ADDR_W-1:0]);
		load_port.din   = load_word.data;
	end

	// Bridges pass through in ST_RUN
	always_comb begin
		instr_port = instr_req;
		data_port  = data_req;
		if (state_q == ST_LOAD) begin
			// Unselected memory stays idle
			instr_port = SRAM_IDLE;
			data_port  = SRAM_IDLE;
			if (load_we) begin
				if (load_word.target == TARGET_INSTR) begin
					instr_port = load_port;
				end else begin
					data_port = load_port;
				end
			end
		end
	end

endmodule

// ==== rtl/dual_mem_top.sv ====
/*
 * Memory side of the RISC-V system.
 * Instruction and data SSRAMs, each behind an OBI bridge, with the
 * preload sequencer between bridges and arrays. Fetch and lsu OBI
 * ports come from the core, the load port from the boot image source.
 * core_rst_n holds the core in reset until the image is written.
 */

module dual_mem_top #(
	parameter int ADDR_W = mem_pkg::SRAM_ADDR_W
) (
	input  logic                tb_CLK,
	input  logic                arst_n,
	// Core fetch port
	input  obi_pkg::obi_req_t   fetch_req,
	output obi_pkg::obi_rsp_t   fetch_rsp,
	// Core load/store port
	input  obi_pkg::obi_req_t   lsu_req,
	output obi_pkg::obi_rsp_t   lsu_rsp,
	// Image preload
	input  logic                load_we,
	input  mem_pkg::load_word_t load_word,
	input  logic                load_done,
	// Reset to the core
	output logic                core_rst_n
);

	import mem_pkg::*;

	// ------------------------------------------------------------
	// Internal wiring
	// ------------------------------------------------------------

	// Bridge requests into the loader
	sram_port_t fetch_sram_req;
	sram_port_t lsu_sram_req;

	// Loader outputs into the arrays
	sram_port_t instr_port;
	sram_port_t data_port;

	// Array read data back to the bridges
	logic [SRAM_DATA_W-1:0] instr_dout;
	logic [SRAM_DATA_W-1:0] data_dout;

	// High once the loader has handed over
	logic bridge_enable;

	// ------------------------------------------------------------
	// Instruction side
	// ------------------------------------------------------------

	ssram_port #(
		.ADDR_W (ADDR_W)
	) u_fetch_port (
		.tb_CLK    (tb_CLK),
		.arst_n    (arst_n),
		.enable    (bridge_enable),
		.obi_req   (fetch_req),
		.obi_rsp   (fetch_rsp),
		.sram_req  (fetch_sram_req),
		.sram_dout (instr_dout)
	);

	sram_array #(
		.ADDR_W (ADDR_W)
	) u_instr_mem (
		.tb_CLK (tb_CLK),
		.port   (instr_port),
		.dout   (instr_dout)
	);

	// ------------------------------------------------------------
	// Data side
	// ------------------------------------------------------------

	ssram_port #(
		.ADDR_W (ADDR_W)
	) u_lsu_port (
		.tb_CLK    (tb_CLK),
		.arst_n    (arst_n),
		.enable    (bridge_enable),
		.obi_req   (lsu_req),
		.obi_rsp   (lsu_rsp),
		.sram_req  (lsu_sram_req),
		.sram_dout (data_dout)
	);

	sram_array #(
		.ADDR_W (ADDR_W)
	) u_data_mem (
		.tb_CLK (tb_CLK),
		.port   (data_port),
		.dout   (data_dout)
	);

	// ------------------------------------------------------------
	// Preload sequencer
	// ------------------------------------------------------------

	mem_loader #(
		.ADDR_W (ADDR_W)
	) u_loader (
		.tb_CLK     (tb_CLK),
		.arst_n     (arst_n),
		.load_we    (load_we),
		.load_word  (load_word),
		.load_done  (load_done),
		.instr_req  (fetch_sram_req),
		.data_req   (lsu_sram_req),
		.instr_port (instr_port),
		.data_port  (data_port),
		.enable     (bridge_enable),
		.core_rst_n (core_rst_n)
	);

endmodule

// ==== dv/tb_dual_mem.sv ====
/*
 * Testbench for the dual memory subsystem.
 * Stands in for the core. It preloads both SRAMs from a load table, then
 * drives fetch and lsu OBI traffic from an access table. Expected read
 * data comes from a reference memory model built with the table.
 * Inputs change on the rising edge and outputs are checked on the falling edge.
 */

module tb_dual_mem;

	import obi_pkg::*;
	import mem_pkg::*;

	// ------------------------------------------------------------
	// Table sizes and limits
	// ------------------------------------------------------------

	localparam int N_WORDS        = 16;
	localparam int LOAD_LEN       = 2 * N_WORDS;
	localparam int ACC_LEN        = 4 * N_WORDS;
	localparam int TIMEOUT_CYCLES = LOAD_LEN + 2 * ACC_LEN + 20;
	localparam int DEPTH          = 2 ** SRAM_ADDR_W;

	localparam logic PORT_FETCH = 1'b0;
	localparam logic PORT_LSU   = 1'b1;

	// One OBI access
	// join_next issues the next row in the same cycle
	typedef struct packed {
		logic        port;
		logic        join_next;
		logic        we;
		logic [3:0]  be;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_rdata;
	} access_t;

	// DUT connections
	logic       tb_CLK;
	logic       arst_n;
	obi_req_t   fetch_req;
	obi_rsp_t   fetch_rsp;
	obi_req_t   lsu_req;
	obi_rsp_t   lsu_rsp;
	logic       load_we;
	load_word_t load_word;
	logic       load_done;
	logic       core_rst_n;

	// Tables and reference model
	load_word_t  load_table [LOAD_LEN];
	access_t     acc_table  [ACC_LEN];
	logic [31:0] ref_instr  [DEPTH];
	logic [31:0] ref_data   [DEPTH];

	integer seed = 32'hb70a1b7d;
	int     error_count = 0;
	int     cycle_count = 0;

	dual_mem_top #(
		.ADDR_W (SRAM_ADDR_W)
	) UUT (
		.tb_CLK     (tb_CLK),
		.arst_n     (arst_n),
		.fetch_req  (fetch_req),
		.fetch_rsp  (fetch_rsp),
		.lsu_req    (lsu_req),
		.lsu_rsp    (lsu_rsp),
		.load_we    (load_we),
		.load_word  (load_word),
		.load_done  (load_done),
		.core_rst_n (core_rst_n)
	);

	initial begin
		tb_CLK = 1'b0;
		forever #50 tb_CLK = ~tb_CLK;
	end

	// Hard stop if the sequence stalls
	always @(posedge tb_CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	task automatic report_error(input string msg);
		error_count++;
		$display("** Error @ %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "first error");
	endtask

	// Only bytes with be set take the new value
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				res[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Spread of data-memory word indexes
	function automatic int data_index(input int n);
		return n * 5 + 2;
	endfunction

	function automatic obi_req_t row_to_req(input access_t row);
		obi_req_t r;
		r.req   = 1'b1;
		r.we    = row.we;
		r.be    = row.be;
		r.addr  = row.addr;
		r.wdata = row.wdata;
		return r;
	endfunction

	task automatic check_rsp(input string name, input obi_rsp_t got, input logic exp_rvalid,
			input logic check_data, input logic [31:0] exp_rdata);
		if (got.rvalid !== exp_rvalid) begin
			report_error($sformatf("%s rvalid %b, expected %b", name, got.rvalid, exp_rvalid));
		end
		if (exp_rvalid && check_data && got.rdata !== exp_rdata) begin
			report_error($sformatf("%s rdata %h, expected %h", name, got.rdata, exp_rdata));
		end
	endtask

	task automatic check_state(input logic exp_core_rst_n, input logic exp_fetch_gnt,
			input logic exp_lsu_gnt);
		if (core_rst_n !== exp_core_rst_n) begin
			report_error($sformatf("core_rst_n %b, expected %b", core_rst_n, exp_core_rst_n));
		end
		if (fetch_rsp.gnt !== exp_fetch_gnt) begin
			report_error($sformatf("fetch gnt %b, expected %b", fetch_rsp.gnt, exp_fetch_gnt));
		end
		if (lsu_rsp.gnt !== exp_lsu_gnt) begin
			report_error($sformatf("lsu gnt %b, expected %b", lsu_rsp.gnt, exp_lsu_gnt));
		end
	endtask

	// ------------------------------------------------------------
	// Table build with the reference model following every write
	// ------------------------------------------------------------

	task automatic build_tables();
		int a;
		access_t row;
		// Instruction and data words interleaved
		for (int n = 0; n < N_WORDS; n++) begin
			load_table[2*n].target     = TARGET_INSTR;
			load_table[2*n].addr       = SRAM_ADDR_W'(n);
			load_table[2*n].data       = $random(seed);
			load_table[2*n + 1].target = TARGET_DATA;
			load_table[2*n + 1].addr   = SRAM_ADDR_W'(data_index(n));
			load_table[2*n + 1].data   = $random(seed);
			ref_instr[n]               = load_table[2*n].data;
			ref_data[data_index(n)]    = load_table[2*n + 1].data;
		end
		a = 0;
		// Fetch reads of every loaded instruction
		for (int n = 0; n < N_WORDS; n++) begin
			row           = '0;
			row.port      = PORT_FETCH;
			row.be        = 4'hf;
			row.addr      = 32'(n * 4);
			row.exp_rdata = ref_instr[n];
			acc_table[a]  = row;
			a++;
		end
		// LSU masked write then read back of the merged word
		for (int n = 0; n < N_WORDS / 2; n++) begin
			row       = '0;
			row.port  = PORT_LSU;
			row.we    = 1'b1;
			row.be    = 4'(n + 1);
			row.addr  = 32'(data_index(n) * 4);
			row.wdata = $random(seed);
			ref_data[data_index(n)] = merge_bytes(ref_data[data_index(n)], row.wdata, row.be);
			acc_table[a] = row;
			a++;
			row.we        = 1'b0;
			row.be        = 4'hf;
			row.wdata     = '0;
			row.exp_rdata = ref_data[data_index(n)];
			acc_table[a]  = row;
			a++;
		end
		// Both ports read every cycle
		for (int n = 0; n < N_WORDS; n++) begin
			row           = '0;
			row.port      = PORT_FETCH;
			row.join_next = 1'b1;
			row.be        = 4'hf;
			row.addr      = 32'((N_WORDS - 1 - n) * 4);
			row.exp_rdata = ref_instr[N_WORDS - 1 - n];
			acc_table[a]  = row;
			a++;
			row.port      = PORT_LSU;
			row.join_next = 1'b0;
			row.addr      = 32'(data_index(n) * 4);
			row.exp_rdata = ref_data[data_index(n)];
			acc_table[a]  = row;
			a++;
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial begin : main_seq
		int i;
		access_t row;
		obi_req_t probe;
		obi_req_t f_req;
		obi_req_t l_req;
		logic [31:0] f_exp;
		logic [31:0] l_exp;
		logic f_pend;
		logic f_pend_rd;
		logic [31:0] f_pend_exp;
		logic l_pend;
		logic l_pend_rd;
		logic [31:0] l_pend_exp;

		arst_n    = 1'b0;
		fetch_req = '0;
		lsu_req   = '0;
		load_we   = 1'b0;
		load_word = '0;
		load_done = 1'b0;
		build_tables();

		// Reset held and nothing granted
		repeat (8) begin
			@(negedge tb_CLK);
			check_state(1'b0, 1'b0, 1'b0);
			check_rsp("fetch", fetch_rsp, 1'b0, 1'b0, '0);
			check_rsp("lsu", lsu_rsp, 1'b0, 1'b0, '0);
		end

		// Requests stay high through the load phase
		probe      = '0;
		probe.req  = 1'b1;
		probe.be   = 4'hf;
		@(posedge tb_CLK);
		arst_n    <= 1'b1;
		fetch_req <= probe;
		lsu_req   <= probe;

		for (i = 0; i < LOAD_LEN; i++) begin
			@(posedge tb_CLK);
			load_we   <= 1'b1;
			load_word <= load_table[i];
			@(negedge tb_CLK);
			check_state(1'b0, 1'b0, 1'b0);
			check_rsp("fetch", fetch_rsp, 1'b0, 1'b0, '0);
			check_rsp("lsu", lsu_rsp, 1'b0, 1'b0, '0);
		end

		@(posedge tb_CLK);
		load_we   <= 1'b0;
		load_done <= 1'b1;
		@(negedge tb_CLK);
		check_state(1'b0, 1'b0, 1'b0);

		// Access phase with response check one cycle behind the request
		f_pend = 1'b0;
		l_pend = 1'b0;
		f_pend_rd = 1'b0;
		l_pend_rd = 1'b0;
		f_pend_exp = '0;
		l_pend_exp = '0;
		i = 0;
		while (i < ACC_LEN + 2) begin
			f_req = '0;
			l_req = '0;
			f_exp = '0;
			l_exp = '0;
			if (i < ACC_LEN) begin
				do begin
					row = acc_table[i];
					i++;
					if (row.port == PORT_FETCH) begin
						f_req = row_to_req(row);
						f_exp = row.exp_rdata;
					end else begin
						l_req = row_to_req(row);
						l_exp = row.exp_rdata;
					end
				end while (row.join_next && i < ACC_LEN);
			end else begin
				// Drain cycles
				i++;
			end
			@(posedge tb_CLK);
			load_done <= 1'b0;
			fetch_req <= f_req;
			lsu_req   <= l_req;
			@(negedge tb_CLK);
			check_state(1'b1, f_req.req, l_req.req);
			check_rsp("fetch", fetch_rsp, f_pend, f_pend_rd, f_pend_exp);
			check_rsp("lsu", lsu_rsp, l_pend, l_pend_rd, l_pend_exp);
			f_pend     = f_req.req;
			f_pend_rd  = ~f_req.we;
			f_pend_exp = f_exp;
			l_pend     = l_req.req;
			l_pend_rd  = ~l_req.we;
			l_pend_exp = l_exp;
		end

		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
rtl/obi_pkg.sv
rtl/mem_pkg.sv
rtl/ssram_port.sv
rtl/sram_array.sv
rtl/mem_loader.sv
rtl/dual_mem_top.sv
dv/tb_dual_mem.sv
